/* vlog.f */
usb_tx_pkg.sv
tx_bit_if.sv
crc_gen.sv
field_shifter.sv
packet_sequencer.sv
bit_stuffer.sv
line_encoder.sv
usb_tx_top.sv
tb_line_monitor.sv
tb_usb_tx.sv

/* Makefile */
TOP := tb_usb_tx

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_usb_tx.sv */
`default_nettype none

module tb_usb_tx import usb_tx_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 400;
  // first bit after SYNC and PID
  localparam int FIELD_START = SYNC_BITS + PID_BITS;

  logic                 clk = 1'b0;
  logic                 rst_L;
  logic                 pkt_avail;
  pid_t                 pid;
  logic [ADDR_BITS-1:0] addr;
  logic [ENDP_BITS-1:0] endp;
  logic [DATA_BITS-1:0] data;
  logic                 ready;
  logic                 pkt_sent;
  logic                 dp;
  logic                 dm;
  logic                 se0;

  logic [127:0] mon_bits;
  int           mon_nbits;
  logic         mon_in_pkt;
  int           mon_run_len;
  int           mon_se0_cnt;
  logic         mon_done;
  int           mon_starts;
  int           mon_ends;
  logic         mon_stuff_err;

  logic [15:0] lfsr = 16'd15925;
  int          errors = 0;
  int          sent_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  always #2 clk = ~clk;

  assign se0 = !dp && !dm;

  usb_tx_top DUT (
    .clk, .rst_L, .pkt_avail, .pid, .addr, .endp, .data, .ready, .pkt_sent, .dp, .dm
  );

  tb_line_monitor u_mon (
    .clk, .rst_L, .dp, .dm, .pkt_bits (mon_bits), .nbits (mon_nbits), .in_pkt (mon_in_pkt),
    .run_len (mon_run_len), .se0_cnt (mon_se0_cnt), .done (mon_done), .starts (mon_starts),
    .ends (mon_ends), .stuff_err (mon_stuff_err)
  );

  // pkt_sent only in the J that closes an EOP, while ready is still low
  sent_in_j: assert property (@(negedge clk) disable iff (!rst_L)
    pkt_sent |-> dp && !dm && $past(se0) && !ready)
    else begin
      $display("mismatch at %0d ns: pkt_sent outside the closing J of an EOP", $time);
      errors++;
    end

  sent_once: assert property (@(negedge clk) disable iff (!rst_L)
    $past(pkt_sent) |-> !pkt_sent && ready)
    else begin
      $display("mismatch at %0d ns: pkt_sent longer than one cycle or ready late", $time);
      errors++;
    end

  eop_shape: assert property (@(negedge clk) disable iff (!rst_L)
    mon_done |-> mon_se0_cnt == EOP_SE0_CYCLES && $past(pkt_sent))
    else begin
      $display("mismatch at %0d ns: EOP had %0d SE0 cycles", $time, mon_se0_cnt);
      errors++;
    end

  run_limit: assert property (@(negedge clk) disable iff (!rst_L)
    mon_in_pkt |-> mon_run_len <= STUFF_RUN + 1)
    else begin
      $display("mismatch at %0d ns: line held one level %0d bits", $time, mon_run_len);
      errors++;
    end

  stuff_zero: assert property (@(negedge clk) disable iff (!rst_L) !mon_stuff_err)
    else begin
      $display("mismatch at %0d ns: six ones not followed by a stuffed zero", $time);
      errors++;
    end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[6'(i)] = lfsr[15];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // serial CRC from all ones whose bits above width the caller ignores
  function automatic logic [15:0] crc_over(input logic [127:0] v, input int first,
                                           input int count, input int width,
                                           input logic [15:0] poly);
    logic [15:0] crc;
    logic        fb;
    crc = '1;
    for (int i = 0; i < count; i++) begin
      fb  = crc[4'(width - 1)] ^ v[7'(first + i)];
      crc = {crc[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
    end
    return crc;
  endfunction

  task automatic verify(input logic ok, input string msg);
    assert (ok) else begin
      $display("mismatch at %0d ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!ready) begin
      $display("timeout: ready stayed low for %0d cycles", TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic wait_sent();
    int n;
    n = 0;
    while (!pkt_sent && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!pkt_sent) begin
      $display("timeout: pkt_sent never came within %0d cycles", TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic send_packet(input pid_t p, input logic [ADDR_BITS-1:0] a,
                             input logic [ENDP_BITS-1:0] e, input logic [DATA_BITS-1:0] d);
    wait_ready();
    pid       = p;
    addr      = a;
    endp      = e;
    data      = d;
    pkt_avail = 1'b1;
    @(posedge clk);
    #1;
    // the DUT latched the fields on that edge
    pkt_avail = 1'b0;
    pid       = PID_ACK;
    addr      = '0;
    endp      = '0;
    data      = '0;
    @(posedge clk);
    #1;
    // ready is low here so this request must be ignored
    pkt_avail = 1'b1;
    @(posedge clk);
    #1;
    pkt_avail = 1'b0;
    sent_count++;
    wait_sent();
    wait_ready();
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic check_packet(input pid_t p, input logic [ADDR_BITS-1:0] a,
                              input logic [ENDP_BITS-1:0] e, input logic [DATA_BITS-1:0] d);
    int exp_len;
    verify(mon_starts == sent_count && mon_ends == sent_count, "one packet per request");
    verify(mon_bits[SYNC_BITS-1:0] == 8'b1000_0000, "SYNC pattern");
    verify(mon_bits[SYNC_BITS +: PID_BITS] == p, "PID");
    case (p)
      PID_OUT, PID_IN: begin
        exp_len = FIELD_START + ADDR_BITS + ENDP_BITS + CRC5_WIDTH;
        verify(mon_bits[FIELD_START +: ADDR_BITS] == a, "address");
        verify(mon_bits[FIELD_START + ADDR_BITS +: ENDP_BITS] == e, "endpoint");
        verify(5'(crc_over(mon_bits, FIELD_START, ADDR_BITS + ENDP_BITS + CRC5_WIDTH,
                           CRC5_WIDTH, 16'(CRC5_POLY))) == CRC5_RESIDUAL, "CRC5 residual");
      end
      PID_DATA0: begin
        exp_len = FIELD_START + DATA_BITS + CRC16_WIDTH;
        verify(mon_bits[FIELD_START +: DATA_BITS] == d, "data payload");
        verify(crc_over(mon_bits, FIELD_START, DATA_BITS + CRC16_WIDTH, CRC16_WIDTH,
                        CRC16_POLY) == CRC16_RESIDUAL, "CRC16 residual");
      end
      default: begin
        // handshakes carry the PID alone
        exp_len = FIELD_START;
      end
    endcase
    verify(mon_nbits == exp_len, "packet length");
  endtask

  task automatic close_test(input string name, input int errs0);
    if (errors == errs0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs0);
    end
  endtask

  task automatic packet_test(input string name, input pid_t p, input logic [ADDR_BITS-1:0] a,
                             input logic [ENDP_BITS-1:0] e, input logic [DATA_BITS-1:0] d);
    int errs0;
    errs0 = errors;
    send_packet(p, a, e, d);
    check_packet(p, a, e, d);
    close_test(name, errs0);
  endtask

  task automatic reset_test();
    int errs0;
    errs0 = errors;
    rst_L = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_L = 1'b1;
    verify(ready === 1'b1, "ready after reset");
    verify(pkt_sent === 1'b0, "pkt_sent after reset");
    verify(dp === 1'b1 && dm === 1'b0, "line idles at J after reset");
    close_test("reset", errs0);
  endtask

  initial begin
    logic [63:0]          r;
    logic [ADDR_BITS-1:0] a;
    logic [ENDP_BITS-1:0] e;
    pkt_avail = 1'b0;
    pid       = PID_NAK;
    addr      = '0;
    endp      = '0;
    data      = '0;
    rst_L     = 1'b0;
    reset_test();

    draw_bits(ADDR_BITS, r);
    a = r[ADDR_BITS-1:0];
    draw_bits(ENDP_BITS, r);
    e = r[ENDP_BITS-1:0];
    packet_test("out_token", PID_OUT, a, e, '0);
    draw_bits(ADDR_BITS, r);
    a = r[ADDR_BITS-1:0];
    draw_bits(ENDP_BITS, r);
    e = r[ENDP_BITS-1:0];
    packet_test("in_token", PID_IN, a, e, '0);

    draw_bits(DATA_BITS, r);
    packet_test("data0_random", PID_DATA0, '0, '0, r);
    // payload fields are present but must not reach the line
    packet_test("ack", PID_ACK, a, e, r);
    packet_test("nak", PID_NAK, a, e, r);

    packet_test("data0_all_ones", PID_DATA0, '0, '0, '1);
    packet_test("token_all_ones", PID_OUT, 7'd127, 4'd15, '0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_line_monitor.sv */
`default_nettype none

// rebuilds the unstuffed bit stream of one packet from dp and dm
module tb_line_monitor import usb_tx_pkg::*; (
  input  logic         clk,
  input  logic         rst_L,
  input  logic         dp,
  input  logic         dm,
  output logic [127:0] pkt_bits,
  output int           nbits,
  output logic         in_pkt,
  output int           run_len,
  output int           se0_cnt,
  output logic         done,
  output int           starts,
  output int           ends,
  output logic         stuff_err
);
  timeunit 1ns;
  timeprecision 1ps;

  logic in_eop;
  logic level_prev;
  logic se0;
  logic bit_now;
  int   ones;

  assign se0 = !dp && !dm;
  // NRZI decode treats a held level as a one
  assign bit_now = (dp == level_prev);

  // the line changes on the rising edge, so it is read on the falling one
  always @(negedge clk or negedge rst_L) begin
    if (!rst_L) begin
      pkt_bits   <= '0;
      nbits      <= 0;
      in_pkt     <= 1'b0;
      in_eop     <= 1'b0;
      run_len    <= 0;
      se0_cnt    <= 0;
      done       <= 1'b0;
      starts     <= 0;
      ends       <= 0;
      stuff_err  <= 1'b0;
      level_prev <= 1'b1;
      ones       <= 0;
    end else begin
      done      <= 1'b0;
      stuff_err <= 1'b0;
      if (in_pkt) begin
        if (se0) begin
          in_pkt  <= 1'b0;
          in_eop  <= 1'b1;
          se0_cnt <= 1;
          // a run of six ones must still be closed by its zero
          if (ones == STUFF_RUN) begin
            stuff_err <= 1'b1;
          end
        end else begin
          level_prev <= dp;
          run_len    <= bit_now ? run_len + 1 : 1;
          if (ones == STUFF_RUN) begin
            // the stuffed zero is dropped from the stream
            ones <= 0;
            if (bit_now) begin
              stuff_err <= 1'b1;
            end
          end else begin
            if (nbits < 128) begin
              pkt_bits[7'(nbits)] <= bit_now;
            end
            nbits <= nbits + 1;
            // SYNC is not part of the stuffing run
            ones  <= (nbits >= SYNC_BITS && bit_now) ? ones + 1 : 0;
          end
        end
      end else if (in_eop) begin
        if (se0) begin
          se0_cnt <= se0_cnt + 1;
        end else begin
          in_eop     <= 1'b0;
          done       <= 1'b1;
          ends       <= ends + 1;
          level_prev <= 1'b1;
        end
      end else if (dm && !dp) begin
        // SYNC opens with a zero, so the line leaves J for K
        in_pkt     <= 1'b1;
        starts     <= starts + 1;
        level_prev <= 1'b0;
        pkt_bits   <= '0;
        nbits      <= 1;
        ones       <= 0;
        run_len    <= 1;
      end
    end
  end

endmodule

`default_nettype wire

/* usb_tx_top.sv */
`default_nettype none

module usb_tx_top import usb_tx_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 pkt_avail,
  input  pid_t                 pid,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [ENDP_BITS-1:0] endp,
  input  logic [DATA_BITS-1:0] data,
  output logic                 ready,
  output logic                 pkt_sent,
  output logic                 dp,
  output logic                 dm
);

  pkt_t       pkt;
  logic       load;
  field_sel_t field_sel;
  logic       field_bit;
  logic       crc5_en;
  logic       crc5_shift;
  logic       crc5_bit;
  logic       crc16_en;
  logic       crc16_shift;
  logic       crc16_bit;
  logic       crc_clr;
  logic       stuffed_bit;
  logic       line_active;
  logic       line_last;

  tx_bit_if tx_bits ();

  assign pkt = '{pid: pid, addr: addr, endp: endp, data: data};

  packet_sequencer u_seq (
    .clk, .rst_L, .pkt_avail, .pid, .pkt_sent, .ready, .load, .field_sel, .field_bit,
    .crc5_en, .crc5_shift, .crc5_bit, .crc16_en, .crc16_shift, .crc16_bit, .crc_clr,
    .bits (tx_bits)
  );

  field_shifter u_fields (
    .clk, .rst_L, .load, .pkt, .field_sel, .stall (tx_bits.stall), .field_bit
  );

  // both CRCs absorb the same field bit, each only in its own states
  crc_gen #(.CRC_WIDTH(CRC5_WIDTH), .POLY(CRC5_POLY), .SEED('1)) u_crc5 (
    .clk, .rst_L, .clr (crc_clr), .en (crc5_en), .shift (crc5_shift),
    .stall (tx_bits.stall), .bit_in (field_bit), .bit_out (crc5_bit)
  );

  crc_gen #(.CRC_WIDTH(CRC16_WIDTH), .POLY(CRC16_POLY), .SEED('1)) u_crc16 (
    .clk, .rst_L, .clr (crc_clr), .en (crc16_en), .shift (crc16_shift),
    .stall (tx_bits.stall), .bit_in (field_bit), .bit_out (crc16_bit)
  );

  bit_stuffer u_stuff (
    .clk, .rst_L, .bits (tx_bits), .stuffed_bit, .line_active, .line_last
  );

  line_encoder u_line (
    .clk, .rst_L, .stuffed_bit, .line_active, .line_last, .dp, .dm, .pkt_sent
  );

endmodule

`default_nettype wire

/* line_encoder.sv */
`default_nettype none

module line_encoder import usb_tx_pkg::*; (
  input  logic clk,
  input  logic rst_L,
  input  logic stuffed_bit,
  input  logic line_active,
  input  logic line_last,
  output logic dp,
  output logic dm,
  output logic pkt_sent
);

  typedef enum logic [1:0] {
    ENC_LINE,
    ENC_SE0,
    ENC_J
  } enc_state_t;

  enc_state_t           state;
  logic [EOP_CNT_W-1:0] se0_cnt;
  logic                 nrzi_nxt;

  // dp already holds the current line level, so NRZI works from it
  assign nrzi_nxt = stuffed_bit ? dp : ~dp;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state    <= ENC_LINE;
      se0_cnt  <= '0;
      dp       <= 1'b1;
      dm       <= 1'b0;
      pkt_sent <= 1'b0;
    end else begin
      pkt_sent <= 1'b0;
      case (state)
        ENC_LINE: begin
          if (line_active) begin
            dp <= nrzi_nxt;
            dm <= ~nrzi_nxt;
            if (line_last) begin
              state   <= ENC_SE0;
              se0_cnt <= '0;
            end
          end
        end
        ENC_SE0: begin
          dp      <= 1'b0;
          dm      <= 1'b0;
          se0_cnt <= se0_cnt + 1'b1;
          if (se0_cnt == EOP_CNT_W'(EOP_SE0_CYCLES - 1)) begin
            state <= ENC_J;
          end
        end
        default: begin
          // closing J of the EOP and the idle level after it
          dp       <= 1'b1;
          dm       <= 1'b0;
          pkt_sent <= 1'b1;
          state    <= ENC_LINE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* bit_stuffer.sv */
`default_nettype none

module bit_stuffer import usb_tx_pkg::*; (
  input  logic    clk,
  input  logic    rst_L,
  tx_bit_if.stuff bits,
  output logic    stuffed_bit,
  output logic    line_active,
  output logic    line_last
);

  logic [SYNC_CNT_W-1:0]  sync_cnt;
  logic [STUFF_CNT_W-1:0] ones;
  logic                   stuffing;
  logic                   last_pending;
  logic                   in_sync;
  logic                   counting;
  logic                   run_full;

  // SYNC bits pass through without being counted
  assign in_sync  = bits.active && (sync_cnt != SYNC_CNT_W'(SYNC_BITS));
  assign counting = bits.active && !in_sync && !stuffing;
  assign run_full = counting && bits.bit_val && (ones == STUFF_CNT_W'(STUFF_RUN - 1));

  assign bits.stall  = stuffing;
  assign stuffed_bit = stuffing ? 1'b0 : bits.bit_val;

  // a stuffed zero after the final bit still belongs to the packet
  assign line_active = bits.active || stuffing;
  assign line_last   = stuffing ? last_pending : (bits.last && !run_full);

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      sync_cnt     <= '0;
      ones         <= '0;
      stuffing     <= 1'b0;
      last_pending <= 1'b0;
    end else begin
      stuffing     <= run_full;
      last_pending <= run_full && bits.last;
      if (!bits.active) begin
        sync_cnt <= '0;
      end else if (in_sync && !stuffing) begin
        sync_cnt <= sync_cnt + 1'b1;
      end
      if (!counting || !bits.bit_val || run_full) begin
        ones <= '0;
      end else begin
        ones <= ones + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* packet_sequencer.sv */
`default_nettype none

module packet_sequencer import usb_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst_L,
  input  logic       pkt_avail,
  input  pid_t       pid,
  input  logic       pkt_sent,
  output logic       ready,
  output logic       load,
  output field_sel_t field_sel,
  input  logic       field_bit,
  output logic       crc5_en,
  output logic       crc5_shift,
  input  logic       crc5_bit,
  output logic       crc16_en,
  output logic       crc16_shift,
  input  logic       crc16_bit,
  output logic       crc_clr,
  tx_bit_if.src      bits
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_SYNC,
    S_PID,
    S_ADDR,
    S_ENDP,
    S_CRC5,
    S_DATA,
    S_CRC16,
    S_WAIT_EOP
  } state_t;

  state_t               state, state_nxt;
  logic [BIT_CNT_W-1:0] bit_cnt;
  pid_t                 pid_q;
  logic                 cnt_end;
  logic                 handshake;

  assign ready     = (state == S_IDLE);
  assign load      = ready && pkt_avail;
  assign crc_clr   = (state == S_IDLE);
  assign handshake = (pid_q == PID_ACK) || (pid_q == PID_NAK);

  always_comb begin
    field_sel    = FS_NONE;
    crc5_en      = 1'b0;
    crc5_shift   = 1'b0;
    crc16_en     = 1'b0;
    crc16_shift  = 1'b0;
    bits.bit_val = 1'b0;
    bits.last    = 1'b0;
    bits.active  = 1'b1;
    cnt_end      = 1'b0;
    state_nxt    = state;
    case (state)
      S_SYNC: begin
        // seven zeros and a closing one, LSB first
        cnt_end      = (bit_cnt == BIT_CNT_W'(SYNC_BITS - 1));
        bits.bit_val = cnt_end;
        state_nxt    = S_PID;
      end
      S_PID: begin
        field_sel    = FS_PID;
        bits.bit_val = field_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(PID_BITS - 1));
        bits.last    = cnt_end && handshake;
        case (pid_q)
          PID_OUT, PID_IN: state_nxt = S_ADDR;
          PID_DATA0:       state_nxt = S_DATA;
          default:         state_nxt = S_WAIT_EOP;
        endcase
      end
      S_ADDR: begin
        field_sel    = FS_ADDR;
        crc5_en      = 1'b1;
        bits.bit_val = field_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(ADDR_BITS - 1));
        state_nxt    = S_ENDP;
      end
      S_ENDP: begin
        field_sel    = FS_ENDP;
        crc5_en      = 1'b1;
        bits.bit_val = field_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(ENDP_BITS - 1));
        state_nxt    = S_CRC5;
      end
      S_CRC5: begin
        crc5_shift   = 1'b1;
        bits.bit_val = crc5_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(CRC5_WIDTH - 1));
        bits.last    = cnt_end;
        state_nxt    = S_WAIT_EOP;
      end
      S_DATA: begin
        field_sel    = FS_DATA;
        crc16_en     = 1'b1;
        bits.bit_val = field_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(DATA_BITS - 1));
        state_nxt    = S_CRC16;
      end
      S_CRC16: begin
        crc16_shift  = 1'b1;
        bits.bit_val = crc16_bit;
        cnt_end      = (bit_cnt == BIT_CNT_W'(CRC16_WIDTH - 1));
        bits.last    = cnt_end;
        state_nxt    = S_WAIT_EOP;
      end
      default: begin
        // idle, or the line encoder is still running the EOP
        bits.active = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
      pid_q   <= PID_NAK;
    end else if (load) begin
      state   <= S_SYNC;
      bit_cnt <= '0;
      pid_q   <= pid;
    end else if (state == S_WAIT_EOP) begin
      if (pkt_sent) begin
        state <= S_IDLE;
      end
    end else if (bits.active && !bits.stall) begin
      if (cnt_end) begin
        bit_cnt <= '0;
        state   <= state_nxt;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* field_shifter.sv */
`default_nettype none

module field_shifter import usb_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst_L,
  input  logic       load,
  input  pkt_t       pkt,
  input  field_sel_t field_sel,
  input  logic       stall,
  output logic       field_bit
);

  logic [PID_BITS-1:0]  pid_sr;
  logic [ADDR_BITS-1:0] addr_sr;
  logic [ENDP_BITS-1:0] endp_sr;
  logic [DATA_BITS-1:0] data_sr;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      pid_sr  <= '0;
      addr_sr <= '0;
      endp_sr <= '0;
      data_sr <= '0;
    end else if (load) begin
      pid_sr  <= pkt.pid;
      addr_sr <= pkt.addr;
      endp_sr <= pkt.endp;
      data_sr <= pkt.data;
    end else if (!stall) begin
      // only the field on the wire moves
      case (field_sel)
        FS_PID:  pid_sr  <= pid_sr >> 1;
        FS_ADDR: addr_sr <= addr_sr >> 1;
        FS_ENDP: endp_sr <= endp_sr >> 1;
        FS_DATA: data_sr <= data_sr >> 1;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (field_sel)
      FS_PID:  field_bit = pid_sr[0];
      FS_ADDR: field_bit = addr_sr[0];
      FS_ENDP: field_bit = endp_sr[0];
      FS_DATA: field_bit = data_sr[0];
      default: field_bit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* crc_gen.sv */
`default_nettype none

module crc_gen import usb_tx_pkg::*; #(
  parameter int                   CRC_WIDTH = CRC5_WIDTH,
  parameter logic [CRC_WIDTH-1:0] POLY      = CRC5_POLY,
  parameter logic [CRC_WIDTH-1:0] SEED      = '1
) (
  input  logic clk,
  input  logic rst_L,
  input  logic clr,
  input  logic en,
  input  logic shift,
  input  logic stall,
  input  logic bit_in,
  output logic bit_out
);

  logic [CRC_WIDTH-1:0] rem;
  logic                 fb;

  assign fb = rem[CRC_WIDTH-1] ^ bit_in;

  // remainder leaves complemented, MSB first
  assign bit_out = ~rem[CRC_WIDTH-1];

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      rem <= SEED;
    end else if (clr) begin
      rem <= SEED;
    end else if (!stall) begin
      if (en) begin
        rem <= {rem[CRC_WIDTH-2:0], 1'b0} ^ (fb ? POLY : '0);
      end else if (shift) begin
        rem <= {rem[CRC_WIDTH-2:0], 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

/* tx_bit_if.sv */
`default_nettype none

// raw serial stream between the packet sequencer and the bit stuffer
interface tx_bit_if;
  logic bit_val;
  logic active;
  logic last;
  // held high for one cycle while a stuffed zero goes out
  logic stall;

  modport src (
    output bit_val, active, last,
    input  stall
  );

  modport stuff (
    input  bit_val, active, last,
    output stall
  );
endinterface

`default_nettype wire

/* usb_tx_pkg.sv */
`default_nettype none

package usb_tx_pkg;

  // field widths of a packet on the wire
  localparam int SYNC_BITS = 8;
  localparam int PID_BITS  = 8;
  localparam int ADDR_BITS = 7;
  localparam int ENDP_BITS = 4;
  localparam int DATA_BITS = 64;

  // token CRC over addr and endp, x^5 + x^2 + 1
  localparam int                    CRC5_WIDTH    = 5;
  localparam logic [CRC5_WIDTH-1:0] CRC5_POLY     = 5'b00101;
  localparam logic [CRC5_WIDTH-1:0] CRC5_RESIDUAL = 5'b01100;

  // data CRC, x^16 + x^15 + x^2 + 1
  localparam int                     CRC16_WIDTH    = 16;
  localparam logic [CRC16_WIDTH-1:0] CRC16_POLY     = 16'h8005;
  localparam logic [CRC16_WIDTH-1:0] CRC16_RESIDUAL = 16'h800D;

  localparam int STUFF_RUN      = 6;
  localparam int EOP_SE0_CYCLES = 2;

  // counter widths derived from the lengths above
  localparam int BIT_CNT_W   = $clog2(DATA_BITS);
  localparam int SYNC_CNT_W  = $clog2(SYNC_BITS + 1);
  localparam int STUFF_CNT_W = $clog2(STUFF_RUN);
  localparam int EOP_CNT_W   = $clog2(EOP_SE0_CYCLES);

  typedef enum logic [PID_BITS-1:0] {
    PID_OUT   = 8'b1110_0001,
    PID_IN    = 8'b0110_1001,
    PID_DATA0 = 8'b1100_0011,
    PID_ACK   = 8'b1101_0010,
    PID_NAK   = 8'b0101_1010
  } pid_t;

  typedef struct packed {
    pid_t                 pid;
    logic [ADDR_BITS-1:0] addr;
    logic [ENDP_BITS-1:0] endp;
    logic [DATA_BITS-1:0] data;
  } pkt_t;

  // which packet field the shifter is walking through
  typedef enum logic [2:0] {
    FS_NONE,
    FS_PID,
    FS_ADDR,
    FS_ENDP,
    FS_DATA
  } field_sel_t;

endpackage

`default_nettype wire
